// File: csc_sync_cfg.svh
`ifndef CSC_SYNC_CFG_SVH
`define CSC_SYNC_CFG_SVH

// ------------------------------------------------------------
// Fiber layout of one chamber
// ------------------------------------------------------------
`define CSC_NUM_CFEB     7   // Front-end board fibers per chamber
`define CSC_ME1B_FIRST   0   // ME1/b boards sit on the low lanes
`define CSC_ME1B_COUNT   4
`define CSC_ME1A_FIRST   4   // ME1/a boards follow directly after
`define CSC_ME1A_COUNT   3

// ------------------------------------------------------------
// Timing
// ------------------------------------------------------------
// Clock cycles between clock lock and the monitor being armed
`define CSC_PWRUP_CYCLES 16
`define CSC_DELAY_DEPTH  16  // Taps in the flag delay line

// ------------------------------------------------------------
// Legal frame markers
// ------------------------------------------------------------
`define CSC_KCHAR_IDLE   8'hBC  // Sent as separator on most frames
`define CSC_KCHAR_MARK   8'hFC  // Replaces BC once every 256 frames

`endif

// File: csc_link_pkg.sv
`include "csc_sync_cfg.svh"

// Types for what arrives from the front-end fibers
package csc_link_pkg;

  // One received K-character from a fiber
  typedef logic [7:0] kchar_t;

  // One bit per fiber, lane 0 in bit 0
  typedef logic [`CSC_NUM_CFEB-1:0] cfeb_mask_t;

  // Receive delay setting, wide enough to pick any delay-line tap
  typedef logic [$clog2(`CSC_DELAY_DEPTH)-1:0] rxd_delay_t;

  // Markers of all fibers side by side with lane 0 in the low byte
  typedef kchar_t [`CSC_NUM_CFEB-1:0] kchar_bus_t;

  // Per-fiber status bits as reported by the receivers
  typedef struct packed {
    cfeb_mask_t fiber_enable;  // Fiber is in use for this chamber
    cfeb_mask_t link_good;     // Receiver reports a good link
    cfeb_mask_t lt_trg_err;    // Local-trigger error seen on the fiber
    cfeb_mask_t sync_done;     // Board has finished its resync
  } link_status_t;

endpackage

// File: csc_sync_pkg.sv
// Types for monitor control and reported sync status
package csc_sync_pkg;

  // ------------------------------------------------------------
  // Power-up and resync sequencing
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    st_wait_lock,  // Waiting for the clock to lock
    st_power_up,   // Lock seen and timer running
    st_ready,      // Monitor armed
    st_hold        // Global reset or resync in progress
  } ready_state_e;

  // ------------------------------------------------------------
  // Status of one board group
  // ------------------------------------------------------------
  typedef struct packed {
    logic synced;    // Group is in step this cycle
    logic lostsync;  // Group has dropped out of step since the last resync
  } group_status_t;

  // Status of the whole chamber, one field per group
  typedef struct packed {
    group_status_t me1b;  // Four ME1/b boards
    group_status_t me1a;  // Three ME1/a boards
  } sync_status_t;

endpackage

// File: sync_ready_fsm.sv
module sync_ready_fsm (
  input  logic clock,
  input  logic arst_n,
  input  logic clk_lock,
  input  logic global_reset,
  input  logic ttc_resync,
  input  logic timer_done,
  output logic timer_start,
  output logic ready
);
  import csc_sync_pkg::*;

  ready_state_e state;
  ready_state_e state_nxt;
  logic         rearm;  // Any cause that must take the monitor out of ready

  assign rearm = global_reset | ttc_resync | ~clk_lock;

  // ------------------------------------------------------------
  // Next-state logic
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      st_wait_lock: begin
        if (clk_lock) state_nxt = st_power_up;  // Lock seen so start the wait
      end
      st_power_up: begin
        // A pulse during the start cycle belongs to an older count
        if (!clk_lock) begin
          state_nxt = st_wait_lock;
        end else if (timer_done && !timer_start) begin
          state_nxt = rearm ? st_hold : st_ready;
        end
      end
      st_ready: begin
        if (rearm) state_nxt = st_hold;  // Ready drops on the next edge
      end
      st_hold: begin
        // Lost lock means the whole power-up wait is repeated
        if (!clk_lock) begin
          state_nxt = st_wait_lock;
        end else if (!(global_reset || ttc_resync)) begin
          state_nxt = st_ready;
        end
      end
      default: state_nxt = st_wait_lock;
    endcase
  end

  // ------------------------------------------------------------
  // State and registered outputs
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_wait_lock;
      timer_start <= 1'b0;
      ready       <= 1'b0;
    end else begin
      state       <= state_nxt;
      timer_start <= (state == st_wait_lock) && (state_nxt == st_power_up);  // One pulse per lock
      ready       <= (state_nxt == st_ready);  // Registered together with the state
    end
  end

  // Any cause for a rearm takes ready away on the next edge
  a_ready_drops: assert property (@(posedge clock) disable iff (!arst_n)
    rearm |=> !ready);

  // The first lock seen while waiting kicks off the timer
  a_start_on_lock: assert property (@(posedge clock) disable iff (!arst_n)
    (state == st_wait_lock) && clk_lock |=> timer_start);

endmodule

// File: powerup_timer.sv
`include "csc_sync_cfg.svh"

module powerup_timer (
  input  logic clock,
  input  logic arst_n,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`CSC_PWRUP_CYCLES + 1);

  logic [CNT_W-1:0] count;  // Cycles left before done, zero when idle

  // ------------------------------------------------------------
  // Down-counter
  // ------------------------------------------------------------
  // The load cycle itself counts as one of the wait cycles
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
      done  <= 1'b0;
    end else if (start) begin
      count <= CNT_W'(`CSC_PWRUP_CYCLES - 1);  // A new start always reloads
      done  <= 1'b0;
    end else if (count != '0) begin
      count <= count - 1'b1;
      done  <= (count == CNT_W'(1));  // Fires on the step to zero
    end else begin
      done  <= 1'b0;  // Idle until the next start
    end
  end

  // Done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    done |=> !done);

endmodule

// File: sync_delay_line.sv
`include "csc_sync_cfg.svh"

module sync_delay_line #(
  parameter int WIDTH = 2
) (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic [WIDTH-1:0]          flags_in,
  input  csc_link_pkg::rxd_delay_t  tap,
  output logic [WIDTH-1:0]          flags_out
);

  // ------------------------------------------------------------
  // Shift register
  // ------------------------------------------------------------
  // Stage 0 holds the flags from one cycle ago, stage n from n+1 cycles ago
  logic [`CSC_DELAY_DEPTH-1:0][WIDTH-1:0] stage;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      stage <= '0;  // No stale flags after reset
    end else begin
      stage <= {stage[`CSC_DELAY_DEPTH-2:0], flags_in};  // New flags enter at the bottom
    end
  end

  // ------------------------------------------------------------
  // Tap select
  // ------------------------------------------------------------
  // The tap may change at run time and takes effect at once
  assign flags_out = stage[tap];  // Total delay is tap+1 cycles

endmodule

// File: cfeb_group_check.sv
`include "csc_sync_cfg.svh"

module cfeb_group_check #(
  parameter int FIRST = 0,
  parameter int COUNT = 4
) (
  input  logic                         clock,
  input  logic                         arst_n,
  input  logic                         ready,
  input  csc_link_pkg::kchar_bus_t     kchars,
  input  csc_link_pkg::link_status_t   link_stat,
  input  csc_link_pkg::rxd_delay_t     rxd_delay,
  output csc_sync_pkg::group_status_t  group_status
);
  import csc_link_pkg::*;

  localparam int KW = $bits(kchar_t);

  kchar_t [COUNT-1:0] lane_kchar;  // Markers of this group only
  logic   [COUNT-1:0] lane_en;
  logic   [COUNT-1:0] lane_good;
  logic   [COUNT-1:0] lane_err;
  logic   [COUNT-1:0] lane_done;
  logic   [COUNT-1:0] good_r1;     // Link-good history one and two cycles back
  logic   [COUNT-1:0] good_r2;
  logic   [COUNT-1:0] skip;        // Lane left out of the comparison this cycle
  logic   [COUNT-1:0] in_table;    // Lane is skipped or carries a legal marker
  kchar_t             or_kchar;
  kchar_t             and_kchar;
  logic               done_dly;    // Group resync done, delayed
  logic               err_dly;     // Group trigger error, delayed
  logic               group_sync;

  assign lane_kchar = kchars[FIRST +: COUNT];
  assign lane_en    = link_stat.fiber_enable[FIRST +: COUNT];
  assign lane_good  = link_stat.link_good[FIRST +: COUNT];
  assign lane_err   = link_stat.lt_trg_err[FIRST +: COUNT];
  assign lane_done  = link_stat.sync_done[FIRST +: COUNT];

  // ------------------------------------------------------------
  // Delayed group flags
  // ------------------------------------------------------------
  // All boards must be done but one board's error is enough
  sync_delay_line #(.WIDTH(2)) u_flag_dly (
    .clock     (clock),
    .arst_n    (arst_n),
    .flags_in  ({&lane_done, |lane_err}),
    .tap       (rxd_delay),
    .flags_out ({done_dly, err_dly})
  );

  // A link that just came back is distrusted for two more cycles
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      good_r1 <= '0;
      good_r2 <= '0;
    end else begin
      good_r1 <= lane_good;
      good_r2 <= good_r1;
    end
  end

  // ------------------------------------------------------------
  // Marker comparison
  // ------------------------------------------------------------
  // OR and AND over the unskipped markers agree only if all of them are equal
  always_comb begin
    or_kchar  = '0;
    and_kchar = '1;
    for (int i = 0; i < COUNT; i++) begin
      skip[i]     = ~lane_good[i] | ~good_r2[i] | ~lane_en[i] | ~ready;
      in_table[i] = skip[i] | (lane_kchar[i] == `CSC_KCHAR_IDLE)
                            | (lane_kchar[i] == `CSC_KCHAR_MARK);
      or_kchar    = or_kchar  | (lane_kchar[i] & {KW{~skip[i]}});   // Skipped lanes add nothing
      and_kchar   = and_kchar & (lane_kchar[i] | {KW{ skip[i]}});   // Skipped lanes read as all ones
    end
    // With every lane skipped the two reductions differ so that case is named on its own
    group_sync = ((or_kchar == and_kchar) && (&in_table) && !err_dly) || (&skip);
  end

  // ------------------------------------------------------------
  // Status registers
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      group_status.synced   <= 1'b1;
      group_status.lostsync <= 1'b0;
    end else if (!ready || !done_dly) begin
      group_status.synced   <= 1'b1;  // Nothing is judged until the boards are resynced
      group_status.lostsync <= 1'b0;
    end else begin
      group_status.synced   <= group_sync;
      group_status.lostsync <= group_status.lostsync | ~group_sync;  // Sticky until rearmed
    end
  end

  // A group that is out of step has always latched the loss
  a_loss_latched: assert property (@(posedge clock) disable iff (!arst_n)
    !group_status.synced |-> group_status.lostsync);

endmodule

// File: csc_sync_mon.sv
`include "csc_sync_cfg.svh"

module csc_sync_mon (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        clk_lock,
  input  logic                        global_reset,
  input  logic                        ttc_resync,
  input  csc_link_pkg::kchar_bus_t    kchars,
  input  csc_link_pkg::link_status_t  link_stat,
  input  csc_link_pkg::rxd_delay_t    rxd_delay,       // Flag delay for ME1/b
  input  csc_link_pkg::rxd_delay_t    rxd_delay_me1a,  // Flag delay for ME1/a
  output logic                        monitor_ready,
  output csc_sync_pkg::sync_status_t  status
);

  logic timer_start;  // Pulse from the FSM when clock lock is first seen
  logic timer_done;   // Pulse when the power-up wait is over
  logic ready;        // Monitor armed, low during power-up and resync

  // ------------------------------------------------------------
  // Power-up and resync sequencing
  // ------------------------------------------------------------
  sync_ready_fsm u_fsm (
    .clock        (clock),
    .arst_n       (arst_n),
    .clk_lock     (clk_lock),
    .global_reset (global_reset),
    .ttc_resync   (ttc_resync),
    .timer_done   (timer_done),
    .timer_start  (timer_start),
    .ready        (ready)
  );

  powerup_timer u_timer (
    .clock  (clock),
    .arst_n (arst_n),
    .start  (timer_start),
    .done   (timer_done)
  );

  assign monitor_ready = ready;

  // ------------------------------------------------------------
  // Group checkers
  // ------------------------------------------------------------
  // Both see every lane and pick out their own by parameter
  cfeb_group_check #(
    .FIRST (`CSC_ME1B_FIRST),
    .COUNT (`CSC_ME1B_COUNT)
  ) u_me1b (
    .clock        (clock),
    .arst_n       (arst_n),
    .ready        (ready),
    .kchars       (kchars),
    .link_stat    (link_stat),
    .rxd_delay    (rxd_delay),
    .group_status (status.me1b)
  );

  // ME1/a uses its own delay setting for its error path
  cfeb_group_check #(
    .FIRST (`CSC_ME1A_FIRST),
    .COUNT (`CSC_ME1A_COUNT)
  ) u_me1a (
    .clock        (clock),
    .arst_n       (arst_n),
    .ready        (ready),
    .kchars       (kchars),
    .link_stat    (link_stat),
    .rxd_delay    (rxd_delay_me1a),
    .group_status (status.me1a)
  );

endmodule

// File: tb_csc_sync_mon.sv
`include "csc_sync_cfg.svh"

module tb_csc_sync_mon;
  import csc_link_pkg::*;
  import csc_sync_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 8;
  localparam int unsigned SEED         = 32'hb6752124;

  // Cycle budgets of the tests that the watchdog adds up
  localparam int PWRUP_BUDGET    = 5 + `CSC_PWRUP_CYCLES + 4;
  localparam int CLEAN_BUDGET    = 30;
  localparam int MISMATCH_BUDGET = 12;
  localparam int SKIP_BUDGET     = 20;
  localparam int DELAY_BUDGET    = 4 * `CSC_DELAY_DEPTH + 16;  // Two waits that may each reach the deepest tap
  localparam int ILLEGAL_BUDGET  = 10;
  localparam int MARGIN_CYCLES   = 50;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + PWRUP_BUDGET + CLEAN_BUDGET + MISMATCH_BUDGET
                                 + SKIP_BUDGET + DELAY_BUDGET + ILLEGAL_BUDGET + MARGIN_CYCLES;

  // Group status values that the tests expect
  localparam group_status_t in_step   = 2'b10;  // Synced and no loss seen
  localparam group_status_t dropped   = 2'b01;  // Out of step this cycle
  localparam group_status_t recovered = 2'b11;  // Back in step but loss remembered
  localparam sync_status_t  all_in_step = {in_step, in_step};

  logic         clock = 1'b0;
  logic         arst_n;
  logic         clk_lock;
  logic         global_reset;
  logic         ttc_resync;
  kchar_bus_t   kchars;
  link_status_t link_stat;
  rxd_delay_t   rxd_delay;
  rxd_delay_t   rxd_delay_me1a;
  logic         monitor_ready;
  sync_status_t status;

  csc_sync_mon u_dut (
    .clock          (clock),
    .arst_n         (arst_n),
    .clk_lock       (clk_lock),
    .global_reset   (global_reset),
    .ttc_resync     (ttc_resync),
    .kchars         (kchars),
    .link_stat      (link_stat),
    .rxd_delay      (rxd_delay),
    .rxd_delay_me1a (rxd_delay_me1a),
    .monitor_ready  (monitor_ready),
    .status         (status)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  // Outputs have settled and new inputs go in one unit after the edge
  task step_cycle;
    @(posedge clock);
    #1;
  endtask

  // Every lane enabled, linked, resynced and sending the idle marker
  task drive_clean_links;
    for (int i = 0; i < `CSC_NUM_CFEB; i++) begin
      kchars[i] = `CSC_KCHAR_IDLE;
    end
    link_stat.fiber_enable = '1;
    link_stat.link_good    = '1;
    link_stat.lt_trg_err   = '0;
    link_stat.sync_done    = '1;
  endtask

  function automatic int lane_group(input int lane);
    return (lane >= `CSC_ME1A_FIRST) ? 1 : 0;  // 0 is ME1/b and 1 is ME1/a
  endfunction

  function automatic int pick_lane(input int grp);
    if (grp == 0) begin
      return `CSC_ME1B_FIRST + int'($urandom % `CSC_ME1B_COUNT);
    end
    return `CSC_ME1A_FIRST + int'($urandom % `CSC_ME1A_COUNT);
  endfunction

  // Chamber status with one group set to hit and the other in step
  function automatic sync_status_t one_group(input int grp, input group_status_t hit);
    sync_status_t s;
    s = all_in_step;
    if (grp == 0) s.me1b = hit;
    else          s.me1a = hit;
    return s;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task check_status(input sync_status_t exp, input string what);
    if (status !== exp) begin
      $display("mismatch at %0t: %s, status expected %b got %b", $time, what, exp, status);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task check_ready(input logic exp, input string what);
    if (monitor_ready !== exp) begin
      $display("mismatch at %0t: %s, monitor_ready expected %b got %b",
               $time, what, exp, monitor_ready);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task hold_and_check(input int cycles, input sync_status_t exp, input string what);
    repeat (cycles) begin
      step_cycle();
      check_status(exp, what);
    end
  endtask

  // A one-cycle TTC resync drops ready for a cycle and clears the sticky flags
  task resync_pulse(input string what);
    ttc_resync = 1'b1;
    step_cycle();
    check_ready(1'b0, {what, " resync drops ready"});
    ttc_resync = 1'b0;
    step_cycle();
    check_ready(1'b1, {what, " ready back after resync"});
    check_status(all_in_step, {what, " status cleared by resync"});
    step_cycle();
    check_status(all_in_step, {what, " status stays clear"});
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task power_up_wait;
    repeat (5) begin  // No lock yet so nothing may arm
      step_cycle();
      check_ready(1'b0, "ready before lock");
      check_status(all_in_step, "status before lock");
    end
    clk_lock = 1'b1;
    // Start pulse, the timer wait and the ready register make PWRUP+2 cycles
    for (int k = 1; k <= `CSC_PWRUP_CYCLES + 1; k++) begin
      step_cycle();
      check_ready(1'b0, "ready during power-up wait");
      check_status(all_in_step, "status during power-up wait");
    end
    step_cycle();
    check_ready(1'b1, "ready after power-up wait");
  endtask

  task clean_markers;
    hold_and_check(12, all_in_step, "all lanes on BC");
    for (int i = 0; i < `CSC_NUM_CFEB; i++) begin
      kchars[i] = `CSC_KCHAR_MARK;  // The periodic marker on every lane at once
    end
    hold_and_check(12, all_in_step, "all lanes on FC");
    drive_clean_links();
    hold_and_check(2, all_in_step, "back to BC");
  endtask

  task sticky_mismatch;
    int lane;
    lane = pick_lane(0);
    kchars[lane] = `CSC_KCHAR_MARK;  // One ME1/b lane disagrees for a single cycle
    step_cycle();
    check_status(one_group(0, dropped), "ME1/b lane mismatch");
    kchars[lane] = `CSC_KCHAR_IDLE;
    hold_and_check(4, one_group(0, recovered), "ME1/b loss is sticky");
    resync_pulse("mismatch");
  endtask

  task lane_skipping;
    int lane;
    int grp;
    lane = int'($urandom % `CSC_NUM_CFEB);
    grp  = lane_group(lane);
    link_stat.fiber_enable[lane] = 1'b0;
    kchars[lane]                 = 8'h50;  // Junk that would fail if it were compared
    hold_and_check(4, all_in_step, "disabled lane ignored");
    link_stat.fiber_enable[lane] = 1'b1;
    link_stat.link_good[lane]    = 1'b0;
    hold_and_check(4, all_in_step, "bad link ignored");
    link_stat.link_good[lane] = 1'b1;
    // Still distrusted for two cycles after the link comes back
    hold_and_check(2, all_in_step, "link just restored");
    step_cycle();
    check_status(one_group(grp, dropped), "restored lane checked on third cycle");
    kchars[lane] = `CSC_KCHAR_IDLE;
    resync_pulse("lane skip");
  endtask

  task delayed_error_and_gating;
    int grp;
    int lane;
    int dly;
    rxd_delay      = rxd_delay_t'($urandom % `CSC_DELAY_DEPTH);
    // Always differs from the ME1/b setting so each group shows its own delay
    rxd_delay_me1a = rxd_delay_t'(int'(rxd_delay) + 1
                                  + int'($urandom % (`CSC_DELAY_DEPTH - 1)));
    hold_and_check(1, all_in_step, "new delay settings");
    grp  = int'($urandom % 2);
    lane = pick_lane(grp);
    dly  = (grp == 0) ? int'(rxd_delay) : int'(rxd_delay_me1a);
    link_stat.lt_trg_err[lane] = 1'b1;  // A single-cycle trigger error
    for (int k = 1; k <= dly + 1; k++) begin
      step_cycle();
      link_stat.lt_trg_err[lane] = 1'b0;
      check_status(all_in_step, "error still in the delay line");
    end
    step_cycle();
    check_status(one_group(grp, dropped), "delayed error reaches its group");
    step_cycle();
    check_status(one_group(grp, recovered), "error gone but loss kept");
    resync_pulse("delayed error");

    // Set a loss first so the forcing by sync_done is visible
    grp  = int'($urandom % 2);
    lane = pick_lane(grp);
    dly  = (grp == 0) ? int'(rxd_delay) : int'(rxd_delay_me1a);
    kchars[lane] = `CSC_KCHAR_MARK;
    step_cycle();
    check_status(one_group(grp, dropped), "mismatch before sync_done drop");
    kchars[lane]              = `CSC_KCHAR_IDLE;
    link_stat.sync_done[lane] = 1'b0;
    for (int k = 1; k <= dly + 1; k++) begin
      step_cycle();
      check_status(one_group(grp, recovered), "sync_done drop still delayed");
    end
    step_cycle();
    check_status(all_in_step, "delayed sync_done drop forces status");
    link_stat.sync_done[lane] = 1'b1;
    hold_and_check(dly + 3, all_in_step, "sync_done restored");
  endtask

  task illegal_common_marker;
    for (int i = `CSC_ME1A_FIRST; i < `CSC_ME1A_FIRST + `CSC_ME1A_COUNT; i++) begin
      kchars[i] = 8'h3C;  // Equal on every lane but not a frame marker
    end
    step_cycle();
    check_status(one_group(1, dropped), "illegal common marker on ME1/a");
    drive_clean_links();
    step_cycle();
    check_status(one_group(1, recovered), "ME1/a loss kept after illegal marker");
    resync_pulse("illegal marker");
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    arst_n         = 1'b0;
    clk_lock       = 1'b0;
    global_reset   = 1'b0;
    ttc_resync     = 1'b0;
    rxd_delay      = '0;
    rxd_delay_me1a = '0;
    drive_clean_links();
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    arst_n = 1'b1;

    power_up_wait();
    clean_markers();
    sticky_mismatch();
    lane_skipping();
    delayed_error_and_gating();
    illegal_common_marker();

    $display("Simulation passed");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: sim.f
+incdir+.
csc_link_pkg.sv
csc_sync_pkg.sv
sync_ready_fsm.sv
powerup_timer.sv
sync_delay_line.sv
cfeb_group_check.sv
csc_sync_mon.sv
tb_csc_sync_mon.sv
